// File: src/icache_pkg.sv
// instruction cache shared definitions
// geometry, vector types and the port structs of the fetch side
// and the reduced AXI read channel

package icache_pkg;

  // ========================================
  // geometry
  // ========================================
  localparam int ADDR_W      = 32;
  localparam int BLOCK_WORDS = 4;
  localparam int SETS        = 64;
  localparam int OFS_W       = 4;
  localparam int INDEX_W     = 6;
  localparam int TAG_W       = ADDR_W - INDEX_W - OFS_W;

  // ========================================
  // vector types
  // ========================================
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  // word 0 sits in the low bits
  typedef logic [BLOCK_WORDS-1:0][31:0] line_t;

  // ========================================
  // port structs
  // ========================================
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic   valid;
    addr_t  addr;
    instr_t instr;
  } fetch_rsp_t;

  // line-aligned read request, burst of BLOCK_WORDS beats
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } axi_ar_t;

  typedef struct packed {
    logic   valid;
    instr_t data;
    logic   last;
  } axi_r_t;

endpackage

// File: src/icache_sram.sv
// simple dual-port RAM for cache data and tags
// one write port, one read port, registered read
// a read of the address being written returns the new word

`timescale 1ns/10ps

module icache_sram #(
  parameter int WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  we_i,
  input  icache_pkg::index_t    waddr_i,
  input  logic [WIDTH-1:0]      wdata_i,
  input  icache_pkg::index_t    raddr_i,
  output logic [WIDTH-1:0]      rdata_o
);

  logic [WIDTH-1:0] mem [icache_pkg::SETS];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // write-first bypass on a same-edge collision
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// File: src/icache_plru.sv
// tree pseudo-LRU for the instruction cache
// WAY_NUM-1 node bits per set, heap ordered from the root
// node bit 0 points to the lower half, 1 to the upper half

`timescale 1ns/10ps

module icache_plru #(
  parameter int WAY_NUM = 4,
  localparam int WAY_W = $clog2(WAY_NUM)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  icache_pkg::index_t rd_index_i,
  output logic [WAY_W-1:0]   victim_o,
  input  logic               upd_i,
  input  icache_pkg::index_t upd_index_i,
  input  logic [WAY_W-1:0]   upd_way_i
);

  logic [WAY_NUM-2:0] tree_q [icache_pkg::SETS];

  // follow the node bits from the root down to a leaf
  function automatic logic [WAY_W-1:0] walk(input logic [WAY_NUM-2:0] tree);
    int node;
    logic [WAY_W-1:0] way;
    node = 0;
    way  = '0;
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      way[WAY_W-1-lvl] = tree[node];
      node = 2 * node + 1 + int'(tree[node]);
    end
    return way;
  endfunction

  // every node on the path now points away from the way
  function automatic logic [WAY_NUM-2:0] touch(input logic [WAY_NUM-2:0] tree,
                                               input logic [WAY_W-1:0]   way);
    logic [WAY_NUM-2:0] nxt;
    logic b;
    int node;
    nxt  = tree;
    node = 0;
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      b = way[WAY_W-1-lvl];
      nxt[node] = ~b;
      node = 2 * node + 1 + int'(b);
    end
    return nxt;
  endfunction

  assign victim_o = walk(tree_q[rd_index_i]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        tree_q[s] <= '0;
      end
    end else if (upd_i) begin
      tree_q[upd_index_i] <= touch(tree_q[upd_index_i], upd_way_i);
    end
  end

endmodule

// File: src/icache_lookup.sv
// instruction cache lookup pipeline
// stage 0 presents the set index to the tag and data RAMs,
// stage 1 compares tags, returns the word and reports a miss;
// a refilled line is written into the victim way of the stage 1 set

`timescale 1ns/10ps

module icache_lookup #(
  parameter int WAY_NUM = 4,
  localparam int WAY_W = $clog2(WAY_NUM)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   req_ready_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  input  logic                   rsp_ready_i,
  output logic                   miss_o,
  output icache_pkg::addr_t      miss_addr_o,
  input  logic                   fill_i,
  input  icache_pkg::line_t      fill_line_i
);

  localparam int OFS_W = icache_pkg::OFS_W;

  // stage 1 request
  logic              s1_valid_q;
  icache_pkg::addr_t s1_addr_q;
  icache_pkg::index_t s1_index;
  icache_pkg::tag_t   s1_tag;

  icache_pkg::index_t rd_index;
  icache_pkg::line_t  data_rd [WAY_NUM];
  icache_pkg::tag_t   tag_rd [WAY_NUM];
  logic [WAY_NUM-1:0] valid_q [icache_pkg::SETS];
  logic [WAY_NUM-1:0] fill_we;

  logic [WAY_NUM-1:0] hit_vec;
  logic               hit;
  logic [WAY_W-1:0]   hit_way;
  logic [WAY_W-1:0]   plru_way;
  logic [WAY_W-1:0]   victim_way;
  logic               rsp_fire;

  assign s1_index = s1_addr_q[OFS_W +: icache_pkg::INDEX_W];
  assign s1_tag   = s1_addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];

  // ========================================
  // stage 0
  // ========================================
  assign rsp_fire    = fetch_rsp_o.valid && rsp_ready_i;
  assign req_ready_o = !s1_valid_q || rsp_fire;

  // re-read the stage 1 set while stalled so a fill shows up next cycle
  assign rd_index = req_ready_o ? fetch_req_i.addr[OFS_W +: icache_pkg::INDEX_W] : s1_index;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      s1_valid_q <= fetch_req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready_o && fetch_req_i.valid) begin
      s1_addr_q <= fetch_req_i.addr;
    end
  end

  // ========================================
  // stage 1
  // ========================================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      hit_vec[w] = valid_q[s1_index][w] && (tag_rd[w] == s1_tag);
      if (hit_vec[w]) begin
        hit_way = WAY_W'(w);
      end
    end
    hit = |hit_vec;
  end

  always_comb begin
    fetch_rsp_o.valid = s1_valid_q && hit;
    fetch_rsp_o.addr  = s1_addr_q;
    fetch_rsp_o.instr = data_rd[hit_way][s1_addr_q[OFS_W-1:2]];
  end

  assign miss_o      = s1_valid_q && !hit;
  assign miss_addr_o = {s1_addr_q[icache_pkg::ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

  // lowest invalid way first, else the PLRU pick
  always_comb begin
    victim_way = plru_way;
    for (int w = WAY_NUM - 1; w >= 0; w--) begin
      if (!valid_q[s1_index][w]) begin
        victim_way = WAY_W'(w);
      end
    end
    for (int w = 0; w < WAY_NUM; w++) begin
      fill_we[w] = fill_i && (victim_way == WAY_W'(w));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (fill_i) begin
      valid_q[s1_index][victim_way] <= 1'b1;
    end
  end

  // ========================================
  // way storage and replacement state
  // ========================================
  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    icache_sram #(
      .WIDTH($bits(icache_pkg::line_t))
    ) data_ram_inst (
      .clk     (clk),
      .we_i    (fill_we[w]),
      .waddr_i (s1_index),
      .wdata_i (fill_line_i),
      .raddr_i (rd_index),
      .rdata_o (data_rd[w])
    );

    icache_sram #(
      .WIDTH(icache_pkg::TAG_W)
    ) tag_ram_inst (
      .clk     (clk),
      .we_i    (fill_we[w]),
      .waddr_i (s1_index),
      .wdata_i (s1_tag),
      .raddr_i (rd_index),
      .rdata_o (tag_rd[w])
    );
  end

  // touch the way of every consumed hit
  icache_plru #(
    .WAY_NUM(WAY_NUM)
  ) plru_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_index_i  (s1_index),
    .victim_o    (plru_way),
    .upd_i       (rsp_fire),
    .upd_index_i (s1_index),
    .upd_way_i   (hit_way)
  );

endmodule

// File: src/icache_refill.sv
// instruction cache miss handler
// issues one line read on the AXI read channel, gathers the beats
// and hands the full line to the lookup stage on the last beat

`timescale 1ns/10ps

module icache_refill (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                miss_i,
  input  icache_pkg::addr_t   miss_addr_i,
  output icache_pkg::axi_ar_t ar_o,
  input  logic                ar_ready_i,
  input  icache_pkg::axi_r_t  r_i,
  output logic                r_ready_o,
  output logic                fill_o,
  output icache_pkg::line_t   fill_line_o
);

  localparam int WORDS = icache_pkg::BLOCK_WORDS;
  localparam int CNT_W = $clog2(WORDS);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    REFILL
  } state_e;

  state_e     state_q;
  logic [CNT_W-1:0] beat_q;
  // last beat goes straight to the line, so only WORDS-1 are kept
  logic [WORDS-2:0][31:0] buf_q;
  logic       beat_ok;

  assign beat_ok = (state_q == REFILL) && r_i.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (miss_i) state_q <= REQ;
        REQ:     if (ar_ready_i) state_q <= REFILL;
        REFILL:  if (beat_ok && r_i.last) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // beat counter, restarts for every burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (state_q != REFILL) begin
      beat_q <= '0;
    end else if (beat_ok) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_ok && !r_i.last) begin
      buf_q[beat_q] <= r_i.data;
    end
  end

  // miss address is held by stage 1 for the whole miss
  assign ar_o.valid = (state_q == REQ);
  assign ar_o.addr  = miss_addr_i;
  assign r_ready_o  = (state_q == REFILL);

  assign fill_o      = beat_ok && r_i.last;
  assign fill_line_o = {r_i.data, buf_q};

endmodule

// File: src/icache_top.sv
// set-associative instruction cache
// two-stage lookup with a single 32-bit fetch port,
// line refill over a reduced AXI read channel

`timescale 1ns/10ps

module icache_top #(
  parameter int WAY_NUM = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   req_ready_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  input  logic                   rsp_ready_i,
  output icache_pkg::axi_ar_t    ar_o,
  input  logic                   ar_ready_i,
  input  icache_pkg::axi_r_t     r_i,
  output logic                   r_ready_o
);

  // lookup to refill
  logic              miss;
  icache_pkg::addr_t miss_addr;
  // refill back to lookup
  logic              fill;
  icache_pkg::line_t fill_line;

  icache_lookup #(
    .WAY_NUM(WAY_NUM)
  ) lookup_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req_i (fetch_req_i),
    .req_ready_o (req_ready_o),
    .fetch_rsp_o (fetch_rsp_o),
    .rsp_ready_i (rsp_ready_i),
    .miss_o      (miss),
    .miss_addr_o (miss_addr),
    .fill_i      (fill),
    .fill_line_i (fill_line)
  );

  icache_refill refill_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss_i      (miss),
    .miss_addr_i (miss_addr),
    .ar_o        (ar_o),
    .ar_ready_i  (ar_ready_i),
    .r_i         (r_i),
    .r_ready_o   (r_ready_o),
    .fill_o      (fill),
    .fill_line_o (fill_line)
  );

endmodule

// File: tests/tb_icache.sv
// testbench for the instruction cache
// random fetches over a few aliasing sets, a memory responder on the
// AXI read channel and a reference model of tags, valid bits and PLRU

`timescale 1ns/10ps

module tb_icache;

  localparam int WAYS       = 4;
  localparam int NUM_REQ    = 400;
  // about 30 cycles for each request
  localparam int MAX_CYCLES = NUM_REQ * 30;
  localparam int OFS_W      = icache_pkg::OFS_W;
  localparam int INDEX_W    = icache_pkg::INDEX_W;
  localparam icache_pkg::instr_t MEM_KEY = 32'h5a3c_96e1;

  logic                   clk;
  logic                   rst_n;
  icache_pkg::fetch_req_t fetch_req;
  logic                   req_ready;
  icache_pkg::fetch_rsp_t fetch_rsp;
  logic                   rsp_ready;
  icache_pkg::axi_ar_t    ar;
  logic                   ar_ready;
  icache_pkg::axi_r_t     r_beat;
  logic                   r_ready;

  // reference model state
  icache_pkg::tag_t  model_tag [icache_pkg::SETS][WAYS];
  logic [WAYS-1:0]   model_valid [icache_pkg::SETS];
  // [0] root, [1] ways 0/1, [2] ways 2/3
  logic [2:0]        model_tree [icache_pkg::SETS];
  icache_pkg::addr_t acc_q [$];
  icache_pkg::addr_t ar_exp_q [$];

  // memory responder
  logic              rd_active;
  icache_pkg::addr_t rd_base;
  int                rd_beat;

  icache_top #(
    .WAY_NUM(WAYS)
  ) icache_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req_i (fetch_req),
    .req_ready_o (req_ready),
    .fetch_rsp_o (fetch_rsp),
    .rsp_ready_i (rsp_ready),
    .ar_o        (ar),
    .ar_ready_i  (ar_ready),
    .r_i         (r_beat),
    .r_ready_o   (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================
  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error [%s] expected %h, actual %h", test, exp, act);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("** Error %s", what);
    abort_run();
  endtask

  function automatic icache_pkg::instr_t mem_word(input icache_pkg::addr_t a);
    return a ^ MEM_KEY;
  endfunction

  function automatic icache_pkg::addr_t line_of(input icache_pkg::addr_t a);
    return {a[icache_pkg::ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  endfunction

  // six tags on two sets, more lines than ways
  function automatic icache_pkg::addr_t random_addr();
    icache_pkg::tag_t   t;
    icache_pkg::index_t s;
    logic [1:0]         w;
    t = icache_pkg::tag_t'(32'h2a0 + $urandom_range(0, 5));
    s = ($urandom_range(0, 1) != 0) ? icache_pkg::index_t'(41) : icache_pkg::index_t'(7);
    w = 2'($urandom_range(0, 3));
    return {t, s, w, 2'b00};
  endfunction

  function automatic int plru_victim(input logic [2:0] t);
    if (!t[0]) begin
      return t[1] ? 1 : 0;
    end
    return t[2] ? 3 : 2;
  endfunction

  // path nodes turn to the other side of the touched way
  function automatic logic [2:0] plru_touch(input logic [2:0] t, input int way);
    logic [2:0] n;
    n = t;
    n[0] = (way < 2);
    if (way < 2) begin
      n[1] = (way == 0);
    end else begin
      n[2] = (way == 2);
    end
    return n;
  endfunction

  task automatic model_access(input icache_pkg::addr_t a, output logic hit);
    icache_pkg::index_t set;
    icache_pkg::tag_t   tag;
    int                 way;
    set = a[OFS_W +: INDEX_W];
    tag = a[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < WAYS; w++) begin
      if (model_valid[set][w] && model_tag[set][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // an empty way wins over the tree
      way = plru_victim(model_tree[set]);
      for (int w = WAYS - 1; w >= 0; w--) begin
        if (!model_valid[set][w]) begin
          way = w;
        end
      end
      model_valid[set][way] = 1'b1;
      model_tag[set][way]   = tag;
    end
    model_tree[set] = plru_touch(model_tree[set], way);
  endtask

  // ========================================
  // stimulus and checks
  // ========================================
  initial begin : main
    logic                   acc;
    logic                   cons;
    logic                   ar_fire;
    logic                   r_fire;
    logic                   hit;
    logic                   check_next;
    logic                   expect_hit;
    logic                   hold_prev;
    int                     issued;
    int                     consumed_cnt;
    int                     seed_draw;
    icache_pkg::addr_t      exp_addr;
    icache_pkg::fetch_rsp_t prev_rsp;
    seed_draw = $urandom(65293);
    rst_n     = 1'b0;
    fetch_req = '0;
    rsp_ready = 1'b0;
    ar_ready  = 1'b0;
    r_beat    = '0;
    rd_active = 1'b0;
    rd_base   = '0;
    rd_beat   = 0;
    check_next   = 1'b0;
    expect_hit   = 1'b0;
    hold_prev    = 1'b0;
    prev_rsp     = '0;
    issued       = 0;
    consumed_cnt = 0;
    for (int s = 0; s < icache_pkg::SETS; s++) begin
      model_valid[s] = '0;
      model_tree[s]  = '0;
    end

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!ar.valid && !r_ready && !fetch_rsp.valid && req_ready)
      else report_problem("outputs are not idle after reset");

    while (consumed_cnt < NUM_REQ) begin
      @(posedge clk);
      acc     = fetch_req.valid && req_ready;
      cons    = fetch_rsp.valid && rsp_ready;
      ar_fire = ar.valid && ar_ready;
      r_fire  = r_beat.valid && r_ready;

      // response one cycle after acceptance only on a hit
      if (check_next) begin
        assert (fetch_rsp.valid == expect_hit)
          else report_mismatch("hit_latency", 32'(expect_hit), 32'(fetch_rsp.valid));
      end
      if (hold_prev) begin
        assert (fetch_rsp.valid)
          else report_problem("a stalled response dropped its valid");
        assert (fetch_rsp.addr == prev_rsp.addr)
          else report_mismatch("rsp_hold", prev_rsp.addr, fetch_rsp.addr);
        assert (fetch_rsp.instr == prev_rsp.instr)
          else report_mismatch("rsp_hold", prev_rsp.instr, fetch_rsp.instr);
      end
      assert (req_ready == (acc_q.size() == 0 || cons))
        else report_mismatch("req_ready", 32'(acc_q.size() == 0 || cons), 32'(req_ready));

      if (cons) begin
        assert (acc_q.size() > 0)
          else report_problem("a response came with no request pending");
        exp_addr = acc_q.pop_front();
        assert (fetch_rsp.addr == exp_addr)
          else report_mismatch("resp_order", exp_addr, fetch_rsp.addr);
        assert (fetch_rsp.instr == mem_word(exp_addr))
          else report_mismatch("resp_instr", mem_word(exp_addr), fetch_rsp.instr);
        consumed_cnt++;
      end

      check_next = acc;
      if (acc) begin
        model_access(fetch_req.addr, hit);
        acc_q.push_back(fetch_req.addr);
        if (!hit) begin
          ar_exp_q.push_back(line_of(fetch_req.addr));
        end
        expect_hit = hit;
        issued++;
      end

      // ready from the AR handshake until the last beat
      assert (r_ready == rd_active)
        else report_mismatch("r_ready", 32'(rd_active), 32'(r_ready));
      if (r_fire) begin
        if (r_beat.last) begin
          rd_active = 1'b0;
        end
        rd_beat++;
      end
      if (ar_fire) begin
        assert (ar_exp_q.size() > 0 && !rd_active)
          else report_problem("a read request was issued with no miss pending");
        exp_addr = ar_exp_q.pop_front();
        assert (ar.addr == exp_addr)
          else report_mismatch("miss_request", exp_addr, ar.addr);
        rd_active = 1'b1;
        rd_base   = ar.addr;
        rd_beat   = 0;
      end

      hold_prev = fetch_rsp.valid && !rsp_ready;
      prev_rsp  = fetch_rsp;

      // drive the next cycle, a pending fetch holds its address
      if (issued >= NUM_REQ) begin
        fetch_req.valid <= 1'b0;
      end else if (acc || !fetch_req.valid) begin
        fetch_req.valid <= ($urandom_range(0, 3) != 0);
        fetch_req.addr  <= random_addr();
      end
      rsp_ready <= ($urandom_range(0, 3) != 0);
      ar_ready  <= ($urandom_range(0, 1) != 0);
      if (rd_active && $urandom_range(0, 2) != 0) begin
        r_beat.valid <= 1'b1;
        r_beat.data  <= mem_word(rd_base + icache_pkg::addr_t'(4 * rd_beat));
        r_beat.last  <= (rd_beat == icache_pkg::BLOCK_WORDS - 1);
      end else begin
        r_beat.valid <= 1'b0;
      end
    end

    assert (ar_exp_q.size() == 0)
      else report_problem("a miss never issued its read request");
    $display("RESULT: PASS");
    $finish;
  end

  // watchdog
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    report_problem("timeout, the requests did not complete in time");
  end

endmodule

// File: compile.f
src/icache_pkg.sv
src/icache_sram.sv
src/icache_plru.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_top.sv
tests/tb_icache.sv

// File: Makefile
# Verilator flow for the instruction cache testbench

TOP := tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
